//--- design/mipsIsaPkg.sv
// ==========================================================
// instruction-set definitions for the MIPS subset core
// opcode and function encodings, field widths and the
// instruction field layout shared by decoder and datapath
// ==========================================================

package mipsIsaPkg;

  // ==========================================================
  // sizes
  // ==========================================================
  localparam int xlen     = 32;
  localparam int regAddrW = 5;
  localparam int opcodeW  = 6;
  localparam int functW   = 6;

  // jal links into this register
  localparam logic [regAddrW-1:0] raReg = 5'd31;

  // ==========================================================
  // encodings
  // ==========================================================
  // primary opcode, bits 31:26
  typedef enum logic [opcodeW-1:0] {
    opRType = 6'h00,
    opJ     = 6'h02,
    opJal   = 6'h03,
    opBeq   = 6'h04,
    opAddi  = 6'h08,
    opLw    = 6'h23,
    opSw    = 6'h2b
  } opcodeE;

  // function code of register format, bits 5:0
  typedef enum logic [functW-1:0] {
    functJr  = 6'h08,
    functAdd = 6'h20,
    functSub = 6'h22,
    functAnd = 6'h24,
    functOr  = 6'h25,
    functSlt = 6'h2a
  } functE;

  // ==========================================================
  // instruction layout
  // ==========================================================
  // register format below the opcode
  typedef struct packed {
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [regAddrW-1:0] rd;
    logic [4:0]          shamt;
    functE               funct;
  } rFieldsT;

  // immediate format below the opcode
  typedef struct packed {
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [15:0]         imm;
  } iFieldsT;

  // three views of the same 26 bits
  typedef union packed {
    rFieldsT     r;
    iFieldsT     i;
    logic [25:0] target;
  } instBodyT;

  typedef struct packed {
    opcodeE   opcode;
    instBodyT body;
  } instFieldsT;

endpackage

//--- design/mipsCorePkg.sv
// ==========================================================
// microarchitecture types of the single-cycle core
// control word, ALU operation and the memory request and
// register write-back bundles seen at the top level
// ==========================================================

package mipsCorePkg;

  import mipsIsaPkg::*;

  // ==========================================================
  // sizes
  // ==========================================================
  // 128 data words, index from byte address bits 8:2
  localparam int dmemAddrW = 7;

  // ==========================================================
  // ALU
  // ==========================================================
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOpE;

  // ==========================================================
  // control word
  // ==========================================================
  typedef struct packed {
    // rd as destination, else rt
    logic  regDst;
    // immediate as second ALU operand
    logic  aluSrc;
    // write back load data
    logic  memToReg;
    logic  regWrite;
    logic  memWrite;
    // beq, taken on zero
    logic  branch;
    // j and jal
    logic  jump;
    // jr
    logic  jumpReg;
    // jal writes pc plus 4 to r31
    logic  link;
    aluOpE aluOp;
  } ctrlT;

  // ==========================================================
  // external bundles
  // ==========================================================
  // data memory request, store taken at the rising edge
  typedef struct packed {
    logic                 writeEn;
    logic [dmemAddrW-1:0] addr;
    logic [xlen-1:0]      wdata;
  } dmemReqT;

  // register write committing at the next edge
  typedef struct packed {
    logic                en;
    logic [regAddrW-1:0] addr;
    logic [xlen-1:0]     data;
  } wbT;

endpackage

//--- design/controlDecoder.sv
// ==========================================================
// main and ALU control of the single-cycle core
// purely combinational, maps opcode and function code of
// the live instruction onto the datapath control word
// ==========================================================

`timescale 1ns/1ns

module controlDecoder
  import mipsIsaPkg::*, mipsCorePkg::*;
(
  input  instFieldsT fields,
  output ctrlT       ctrl
);

  always_comb begin
    // default is a bubble, nothing written, pc plus 4
    ctrl       = '0;
    ctrl.aluOp = aluAdd;

    case (fields.opcode)
      // ==========================================================
      // register format
      // ==========================================================
      opRType: begin
        ctrl.regDst = 1'b1;
        case (fields.body.r.funct)
          functAdd: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluAdd;
          end
          functSub: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluSub;
          end
          functAnd: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluAnd;
          end
          functOr: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluOr;
          end
          functSlt: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluOp    = aluSlt;
          end
          // target comes from rs, no write
          functJr: ctrl.jumpReg = 1'b1;
          // unknown funct stays a bubble
          default: ctrl.regWrite = 1'b0;
        endcase
      end

      // ==========================================================
      // immediate format
      // ==========================================================
      opAddi: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      // address is rs plus offset
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      // compare by subtraction, zero flag decides
      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;
      end

      // ==========================================================
      // jump format
      // ==========================================================
      opJ: ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end

      default: ctrl.regWrite = 1'b0;
    endcase
  end

endmodule

//--- design/regFile.sv
// ==========================================================
// 32 x 32 general register file
// two asynchronous read ports, one write port at the rising
// edge, register 0 reads zero and ignores writes
// ==========================================================

`timescale 1ns/1ns

module regFile
  import mipsIsaPkg::*, mipsCorePkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [regAddrW-1:0] rdAddrA,
  input  logic [regAddrW-1:0] rdAddrB,
  output logic [xlen-1:0]     rdDataA,
  output logic [xlen-1:0]     rdDataB,
  input  wbT                  wb
);

  logic [xlen-1:0] regs [2**regAddrW];

  // ==========================================================
  // write port
  // ==========================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // architectural state starts at zero
      for (int i = 0; i < 2**regAddrW; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.addr != '0)) begin
      // r0 write shows on wb but is dropped here
      regs[wb.addr] <= wb.data;
    end
  end

  // ==========================================================
  // read ports
  // ==========================================================
  // r0 hardwired, same cycle as the address
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

//--- design/alu.sv
// ==========================================================
// 32-bit ALU of the single-cycle core
// add, sub, and, or and signed set-less-than, plus a zero
// flag on the result for beq
// ==========================================================

`timescale 1ns/1ns

module alu
  import mipsIsaPkg::*, mipsCorePkg::*;
(
  input  logic [xlen-1:0] opA,
  input  logic [xlen-1:0] opB,
  input  aluOpE           op,
  output logic [xlen-1:0] result,
  output logic            zero
);

  always_comb begin
    case (op)
      aluAdd: result = opA + opB;
      aluSub: result = opA - opB;
      aluAnd: result = opA & opB;
      aluOr:  result = opA | opB;
      // signed compare, result is 0 or 1
      aluSlt: begin
        result = '0;
        result[0] = ($signed(opA) < $signed(opB));
      end
      default: result = '0;
    endcase
  end

  // beq takes the branch when rs - rt is zero
  assign zero = (result == '0);

endmodule

//--- design/pcUnit.sv
// ==========================================================
// program counter and next-address logic
// picks register jump, jump, taken branch or pc plus 4 and
// provides pc plus 4 as the jal link address
// ==========================================================

`timescale 1ns/1ns

module pcUnit
  import mipsIsaPkg::*, mipsCorePkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  ctrlT            ctrl,
  input  logic            zero,
  input  logic [15:0]     imm,
  input  logic [25:0]     target,
  input  logic [xlen-1:0] regTarget,
  output logic [xlen-1:0] pc,
  output logic [xlen-1:0] linkAddr
);

  logic [xlen-1:0] pcPlus4;
  logic [xlen-1:0] branchOff;
  logic [xlen-1:0] jumpAddr;
  logic [xlen-1:0] pcNext;

  // ==========================================================
  // candidate addresses
  // ==========================================================
  assign pcPlus4   = pc + xlen'(4);
  // word offset, sign extended then times 4
  assign branchOff = {{(xlen-18){imm[15]}}, imm, 2'b00};
  // region bits from pc plus 4
  assign jumpAddr  = {pcPlus4[xlen-1:xlen-4], target, 2'b00};

  // no delay slot, link is the next instruction
  assign linkAddr  = pcPlus4;

  // ==========================================================
  // next pc
  // ==========================================================
  always_comb begin
    if (ctrl.jumpReg) begin
      pcNext = regTarget;
    end else if (ctrl.jump) begin
      pcNext = jumpAddr;
    end else if (ctrl.branch && zero) begin
      pcNext = pcPlus4 + branchOff;
    end else begin
      pcNext = pcPlus4;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      // fetch starts at address 0
      pc <= '0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

//--- design/singleCycleMips.sv
// ==========================================================
// single-cycle core for a small MIPS subset
// fetches inst for instAddr and executes it in one cycle,
// memories are outside, wb exposes every register write
// ==========================================================

`timescale 1ns/1ns

module singleCycleMips
  import mipsIsaPkg::*, mipsCorePkg::*;
(
  input  logic            clk,
  input  logic            rst,
  output logic [xlen-1:0] instAddr,
  input  logic [xlen-1:0] inst,
  output dmemReqT         dmemReq,
  input  logic [xlen-1:0] readData,
  output wbT              wb
);

  instFieldsT          fields;
  ctrlT                ctrl;
  logic [xlen-1:0]     rsData;
  logic [xlen-1:0]     rtData;
  logic [xlen-1:0]     immExt;
  logic [xlen-1:0]     aluB;
  logic [xlen-1:0]     aluResult;
  logic                aluZero;
  logic [xlen-1:0]     linkAddr;
  logic [regAddrW-1:0] destAddr;
  logic [xlen-1:0]     wbData;

  // ==========================================================
  // decode
  // ==========================================================
  // split the live instruction into its fields
  assign fields = instFieldsT'(inst);

  controlDecoder uDecoder (
    .fields (fields),
    .ctrl   (ctrl)
  );

  // ==========================================================
  // operands
  // ==========================================================
  regFile uRegFile (
    .clk     (clk),
    .rst     (rst),
    .rdAddrA (fields.body.i.rs),
    .rdAddrB (fields.body.i.rt),
    .rdDataA (rsData),
    .rdDataB (rtData),
    .wb      (wb)
  );

  // addi, lw and sw offsets are signed
  assign immExt = {{(xlen-16){fields.body.i.imm[15]}}, fields.body.i.imm};
  assign aluB   = ctrl.aluSrc ? immExt : rtData;

  // ==========================================================
  // execute
  // ==========================================================
  alu uAlu (
    .opA    (rsData),
    .opB    (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  pcUnit uPcUnit (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .zero      (aluZero),
    .imm       (fields.body.i.imm),
    .target    (fields.body.target),
    .regTarget (rsData),
    .pc        (instAddr),
    .linkAddr  (linkAddr)
  );

  // ==========================================================
  // memory
  // ==========================================================
  // word index from byte address bits 8:2
  assign dmemReq.writeEn = ctrl.memWrite;
  assign dmemReq.addr    = aluResult[dmemAddrW+1:2];
  assign dmemReq.wdata   = rtData;

  // ==========================================================
  // write-back
  // ==========================================================
  always_comb begin
    // destination, jal wins over rd and rt
    if (ctrl.link) begin
      destAddr = raReg;
    end else if (ctrl.regDst) begin
      destAddr = fields.body.r.rd;
    end else begin
      destAddr = fields.body.i.rt;
    end

    // data, link address or load data or ALU
    if (ctrl.link) begin
      wbData = linkAddr;
    end else if (ctrl.memToReg) begin
      wbData = readData;
    end else begin
      wbData = aluResult;
    end
  end

  // commits at the next rising edge
  assign wb.en   = ctrl.regWrite;
  assign wb.addr = destAddr;
  assign wb.data = wbData;

endmodule

//--- verification/mipsTbPrograms.svh
// ==========================================================
// directed programs for the single-cycle core testbench
// instruction encoders and builders that fill imem, every
// program ends in a jump to itself, included in mipsTb
// ==========================================================

// static lengths, halt loop included
localparam int arithLen  = 37;
localparam int memLen    = 8;
localparam int branchLen = 9;
localparam int jumpLen   = 7;
localparam int undefLen  = 8;
localparam int totalLen  = arithLen + memLen + branchLen + jumpLen + undefLen;

// next free imem word while building
int fillPtr;

// register format, shamt always zero
function automatic logic [31:0] regOp(input logic [5:0] funct, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd);
  return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] immOp(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

// target is a word index
function automatic logic [31:0] jumpTo(input logic [5:0] op, input int wordIdx);
  return {op, 26'(wordIdx)};
endfunction

task automatic emit(input logic [31:0] word);
  imem[fillPtr] = word;
  fillPtr++;
endtask

task automatic newProgram();
  for (int i = 0; i < 256; i++) begin
    imem[i] = '0;
  end
  fillPtr = 0;
endtask

task automatic halt();
  emit(jumpTo(6'h02, fillPtr));
endtask

// ==========================================================
// programs
// ==========================================================
task automatic arithProgram();
  int pick;
  logic [4:0] rs;
  logic [4:0] rt;
  logic [4:0] rd;
  newProgram();
  // r1 = -5, r2 = 7, signed slt both ways
  emit(immOp(6'h08, 5'd0, 5'd1, 16'hfffb));
  emit(immOp(6'h08, 5'd0, 5'd2, 16'd7));
  emit(regOp(6'h2a, 5'd1, 5'd2, 5'd3));
  emit(regOp(6'h2a, 5'd2, 5'd1, 5'd4));
  // random mix over r0..r7, r0 as destination too
  for (int n = 0; n < 30; n++) begin
    pick = $urandom_range(5, 0);
    rs   = 5'($urandom_range(7, 0));
    rt   = 5'($urandom_range(7, 0));
    rd   = 5'($urandom_range(7, 0));
    case (pick)
      0: emit(regOp(6'h20, rs, rt, rd));
      1: emit(regOp(6'h22, rs, rt, rd));
      2: emit(regOp(6'h24, rs, rt, rd));
      3: emit(regOp(6'h25, rs, rt, rd));
      4: emit(regOp(6'h2a, rs, rt, rd));
      default: emit(immOp(6'h08, rs, rd, 16'($urandom)));
    endcase
  end
  // write to r0 then read it back
  emit(regOp(6'h20, 5'd1, 5'd2, 5'd0));
  emit(regOp(6'h20, 5'd0, 5'd1, 5'd5));
  halt();
endtask

task automatic memoryProgram();
  newProgram();
  // base byte address 0x40, word 16
  emit(immOp(6'h08, 5'd0, 5'd1, 16'h0040));
  // -1234
  emit(immOp(6'h08, 5'd0, 5'd2, 16'hfb2e));
  emit(immOp(6'h2b, 5'd1, 5'd2, 16'd8));
  emit(immOp(6'h23, 5'd1, 5'd3, 16'd8));
  // word 25 is never stored
  emit(immOp(6'h23, 5'd0, 5'd4, 16'd100));
  // negative offset, word 15
  emit(immOp(6'h2b, 5'd1, 5'd4, 16'hfffc));
  emit(immOp(6'h23, 5'd1, 5'd5, 16'hfffc));
  halt();
endtask

task automatic branchProgram();
  newProgram();
  emit(immOp(6'h08, 5'd0, 5'd1, 16'd3));
  emit(immOp(6'h08, 5'd0, 5'd2, 16'd0));
  // loop body at word 2, counts r1 down
  emit(immOp(6'h08, 5'd1, 5'd1, 16'hffff));
  emit(immOp(6'h08, 5'd2, 5'd2, 16'd1));
  emit(immOp(6'h04, 5'd1, 5'd0, 16'd1));
  // always taken, back to word 2
  emit(immOp(6'h04, 5'd0, 5'd0, 16'hfffc));
  // r1 = 0, r2 = 3, falls through
  emit(immOp(6'h04, 5'd1, 5'd2, 16'd1));
  emit(immOp(6'h08, 5'd0, 5'd3, 16'd9));
  halt();
endtask

task automatic jumpProgram();
  newProgram();
  emit(immOp(6'h08, 5'd0, 5'd1, 16'd5));
  // call the routine at word 4
  emit(jumpTo(6'h03, 4));
  emit(immOp(6'h08, 5'd0, 5'd2, 16'd7));
  emit(jumpTo(6'h02, 6));
  emit(immOp(6'h08, 5'd1, 5'd3, 16'd1));
  // return through r31
  emit(regOp(6'h08, 5'd31, 5'd0, 5'd0));
  halt();
endtask

task automatic undefProgram();
  newProgram();
  // sources all zero straight after reset
  emit(regOp(6'h25, 5'd2, 5'd3, 5'd1));
  emit(immOp(6'h08, 5'd0, 5'd4, 16'd12));
  emit({6'h3f, 26'($urandom)});
  emit(regOp(6'h3f, 5'd4, 5'd4, 5'd5));
  // shift funct, not in the subset
  emit(regOp(6'h00, 5'd4, 5'd4, 5'd6));
  // andi, not in the subset
  emit(immOp(6'h0c, 5'd4, 5'd7, 16'h00ff));
  emit(regOp(6'h20, 5'd4, 5'd5, 5'd8));
  halt();
endtask

//--- verification/mipsTb.sv
// ==========================================================
// testbench of the single-cycle MIPS subset core
// memories, reference instruction-set model, per-edge
// compare of pc, write-back and store, five programs
// ==========================================================

`timescale 1ns/1ns

module mipsTb
  import mipsIsaPkg::*, mipsCorePkg::*;
();

  localparam int clkPeriod = 4;

  // one step of the model
  typedef struct packed {
    logic [xlen-1:0] nextPc;
    wbT              wb;
    dmemReqT         req;
  } stepT;

  logic            clk;
  logic            rst;
  logic [xlen-1:0] instAddr;
  logic [xlen-1:0] inst;
  dmemReqT         dmemReq;
  logic [xlen-1:0] readData;
  wbT              wb;

  logic [31:0] imem [256];
  logic [31:0] dmem [2**dmemAddrW];

  // model state
  logic [31:0] refMem [2**dmemAddrW];
  logic [31:0] modelRegs [32];
  logic [31:0] modelPc;
  stepT        expStep;

  logic running;
  logic done;
  int   errors;
  int   steps;
  int   passCount;
  int   failCount;

  `include "mipsTbPrograms.svh"

  // every program twice over plus reset cycles
  localparam int watchdogNs = (2 * totalLen + 6 * 5) * clkPeriod + 400;

  singleCycleMips dut_i (
    .clk      (clk),
    .rst      (rst),
    .instAddr (instAddr),
    .inst     (inst),
    .dmemReq  (dmemReq),
    .readData (readData),
    .wb       (wb)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // ==========================================================
  // data memory
  // ==========================================================
  assign readData = dmem[dmemReq.addr];

  always @(posedge clk) begin
    if (rst && dmemReq.writeEn) begin
      dmem[dmemReq.addr] <= dmemReq.wdata;
    end
  end

  // ==========================================================
  // reference model
  // ==========================================================
  function automatic wbT writeTo(input logic [4:0] addr, input logic [31:0] data);
    wbT w;
    w.en   = 1'b1;
    w.addr = addr;
    w.data = data;
    return w;
  endfunction

  function automatic stepT refStep(input logic [31:0] word, input logic [31:0] pc);
    stepT        s;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] pc4;
    a        = modelRegs[word[25:21]];
    b        = modelRegs[word[20:16]];
    imm      = {{16{word[15]}}, word[15:0]};
    addr     = a + imm;
    pc4      = pc + 32'd4;
    s        = '0;
    s.nextPc = pc4;
    case (word[31:26])
      // register format by funct
      6'h00: begin
        case (word[5:0])
          6'h20: s.wb = writeTo(word[15:11], a + b);
          6'h22: s.wb = writeTo(word[15:11], a - b);
          6'h24: s.wb = writeTo(word[15:11], a & b);
          6'h25: s.wb = writeTo(word[15:11], a | b);
          6'h2a: s.wb = writeTo(word[15:11], {31'd0, $signed(a) < $signed(b)});
          6'h08: s.nextPc = a;
          default: s.wb.en = 1'b0;
        endcase
      end
      // addi
      6'h08: s.wb = writeTo(word[20:16], addr);
      // lw, word index from byte address
      6'h23: s.wb = writeTo(word[20:16], refMem[addr[8:2]]);
      // sw
      6'h2b: begin
        s.req.writeEn = 1'b1;
        s.req.addr    = addr[8:2];
        s.req.wdata   = b;
      end
      // beq
      6'h04: begin
        if (a == b) begin
          s.nextPc = pc4 + {imm[29:0], 2'b00};
        end
      end
      6'h02: s.nextPc = {pc4[31:28], word[25:0], 2'b00};
      // jal links the next instruction
      6'h03: begin
        s.wb     = writeTo(5'd31, pc4);
        s.nextPc = {pc4[31:28], word[25:0], 2'b00};
      end
      default: s.wb.en = 1'b0;
    endcase
    return s;
  endfunction

  // ==========================================================
  // compare tasks
  // ==========================================================
  task automatic comparePc(input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
    if (actual !== expected) begin
      $display("Mismatch instAddr: expected %h, actual %h", expected, actual);
      errors++;
    end
  endtask

  // addr and data only count when a write is due
  task automatic compareWb(input wbT expected, input wbT actual);
    if ((actual.en !== expected.en) ||
        (expected.en && ((actual.addr !== expected.addr) ||
                         (actual.data !== expected.data)))) begin
      $display("Mismatch wb at pc %h: expected %h_%h_%h, actual %h_%h_%h", modelPc,
               expected.en, expected.addr, expected.data,
               actual.en, actual.addr, actual.data);
      errors++;
    end
  endtask

  task automatic compareMemReq(input dmemReqT expected, input dmemReqT actual);
    if ((actual.writeEn !== expected.writeEn) ||
        (expected.writeEn && ((actual.addr !== expected.addr) ||
                              (actual.wdata !== expected.wdata)))) begin
      $display("Mismatch dmemReq at pc %h: expected %h_%h_%h, actual %h_%h_%h", modelPc,
               expected.writeEn, expected.addr, expected.wdata,
               actual.writeEn, actual.addr, actual.wdata);
      errors++;
    end
  endtask

  // ==========================================================
  // checker, one instruction per rising edge
  // ==========================================================
  always @(posedge clk) begin
    if (running && !done) begin
      expStep = refStep(imem[modelPc[9:2]], modelPc);
      comparePc(modelPc, instAddr);
      compareWb(expStep.wb, wb);
      compareMemReq(expStep.req, dmemReq);
      if (expStep.wb.en && (expStep.wb.addr != 5'd0)) begin
        modelRegs[expStep.wb.addr] = expStep.wb.data;
      end
      if (expStep.req.writeEn) begin
        refMem[expStep.req.addr] = expStep.req.wdata;
      end
      // jump to itself ends the program
      if (expStep.nextPc == modelPc) begin
        done = 1'b1;
      end
      modelPc = expStep.nextPc;
      steps++;
    end
  end

  initial begin
    #(watchdogNs);
    $display("Timeout: a program did not reach its halt loop in time");
    $display("Test failed");
    $finish;
  end

  // ==========================================================
  // sequencing
  // ==========================================================
  task automatic runTest(input string name);
    int errorsBefore;
    errorsBefore = errors;
    steps        = 0;
    // fresh random data, model copy kept equal
    for (int i = 0; i < 2**dmemAddrW; i++) begin
      dmem[i]   = $urandom;
      refMem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      modelRegs[i] = '0;
    end
    modelPc = '0;
    done    = 1'b0;
    @(negedge clk);
    running = 1'b0;
    rst     = 1'b0;
    inst    = '0;
    repeat (2) @(negedge clk);
    rst     = 1'b1;
    running = 1'b1;
    inst    = imem[instAddr[9:2]];
    while (!done) begin
      @(negedge clk);
      inst = imem[instAddr[9:2]];
    end
    running = 1'b0;
    if (errors == errorsBefore) begin
      passCount++;
      $display("%s: %0d instructions, ok", name, steps);
    end else begin
      failCount++;
      $display("%s: %0d instructions, %0d errors", name, steps, errors - errorsBefore);
    end
  endtask

  initial begin
    void'($urandom(99528));
    clk       = 1'b0;
    rst       = 1'b0;
    inst      = '0;
    running   = 1'b0;
    done      = 1'b0;
    modelPc   = '0;
    errors    = 0;
    passCount = 0;
    failCount = 0;
    arithProgram();
    runTest("arithmetic and logic");
    memoryProgram();
    runTest("memory");
    branchProgram();
    runTest("branches");
    jumpProgram();
    runTest("jumps");
    undefProgram();
    runTest("reset and undefined codes");
    $display("%0d tests passed, %0d tests failed", passCount, failCount);
    if (failCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- singleCycleMips.f
+incdir+verification
design/mipsIsaPkg.sv
design/mipsCorePkg.sv
design/controlDecoder.sv
design/regFile.sv
design/alu.sv
design/pcUnit.sv
design/singleCycleMips.sv
verification/mipsTb.sv

//--- Bender.yml
package:
  name: single_cycle_mips

sources:
  - files:
      - design/mipsIsaPkg.sv
      - design/mipsCorePkg.sv
      - design/controlDecoder.sv
      - design/regFile.sv
      - design/alu.sv
      - design/pcUnit.sv
      - design/singleCycleMips.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/mipsTb.sv
